/* hw/mem_req_pkg.sv */
`default_nettype none

package mem_req_pkg;

    localparam int vreg_bytes = 32;
    localparam int beat_bytes = 4; // cache data path
    localparam int max_elems  = 8;

    typedef logic [19:0] mem_addr_t; // widest address the controller supports

    typedef enum logic {op_load, op_store} mem_op_t;

    typedef enum logic [1:0] {
        elem_one,
        elem_two,
        elem_four,
        elem_eight
    } elem_type_t;

    typedef enum logic [1:0] {
        mem_resting,
        mem_working,
        mem_stall,
        mem_finished
    } mem_status_t;

    // byte lanes for load assembly, beat words for store selection
    typedef union packed {
        logic [vreg_bytes-1:0][7:0]             lanes;
        logic [max_elems-1:0][8*beat_bytes-1:0] beats;
    } vreg_t;

    typedef struct packed {
        logic       is_vector;
        mem_op_t    op;
        elem_type_t etype;
        mem_addr_t  addr;
        logic [3:0] length;
        logic       vm;
        logic [7:0] mask; // one bit per element
        vreg_t      wdata; // scalar store uses low 64 bits
    } core_req_t;

    typedef struct packed {
        logic       is_vector;
        mem_op_t    op;
        elem_type_t etype;
        mem_addr_t  addr;
        logic [3:0] elem_count;
        logic [1:0] elem_beats; // 2 for 8-byte elements
        logic [3:0] addr_step;
        logic [7:0] active;
        vreg_t      wdata;
    } access_plan_t;

    typedef struct packed {
        logic        valid;
        logic [2:0]  elem;
        logic        second; // upper word of an 8-byte element
        logic [31:0] rdata;
    } load_beat_t;

endpackage

`default_nettype wire

/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    typedef enum logic [1:0] {
        cache_nop,
        cache_load,
        cache_store
    } cache_cmd_t;

    typedef enum logic [1:0] {
        cache_resting,
        cache_busy,
        cache_finished // one cycle, rdata valid for loads
    } cache_status_t;

    typedef struct packed {
        cache_cmd_t             cmd;
        mem_req_pkg::mem_addr_t addr;
        mem_req_pkg::elem_type_t size; // never eight, those go as two beats
        logic [31:0]            wdata;
    } cache_req_t;

    typedef struct packed {
        cache_status_t status;
        logic [31:0]   rdata;
    } cache_resp_t;

endpackage

`default_nettype wire

/* hw/access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module access_decode #(
    parameter int addr_width = 20
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      accept,
    input  wire mem_req_pkg::core_req_t    req,
    output mem_req_pkg::access_plan_t      plan
);
    import mem_req_pkg::*;

    access_plan_t next_plan;
    logic [3:0]   limit;
    logic [5:0]   fit_elems;

    always_comb begin
        // elements that fit the vector register, capped at max_elems
        fit_elems = 6'(vreg_bytes >> req.etype);
        limit = (fit_elems > 6'(max_elems)) ? 4'(max_elems) : fit_elems[3:0];

        next_plan.is_vector  = req.is_vector;
        next_plan.op         = req.op;
        next_plan.etype      = req.etype;
        next_plan.addr       = mem_addr_t'(req.addr[addr_width-1:0]);
        next_plan.elem_beats = (req.etype == elem_eight) ? 2'd2 : 2'd1;
        next_plan.addr_step  = 4'd1 << req.etype;
        next_plan.wdata      = req.wdata;

        if (req.is_vector) begin
            next_plan.elem_count = (req.length > limit) ? limit : req.length;
            next_plan.active     = req.vm ? 8'hff : req.mask;
        end else begin
            next_plan.elem_count = 4'd1; // scalar is a single element
            next_plan.active     = 8'hff;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            plan.elem_count <= '0;
            plan.active     <= '0;
        end else if (accept) begin
            plan <= next_plan;
        end
    end

endmodule

`default_nettype wire

/* hw/access_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module access_sequencer #(
    parameter int addr_width = 20
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      req_valid,
    input  wire mem_req_pkg::access_plan_t plan,
    input  wire dcache_pkg::cache_resp_t   cache_resp,
    output logic                           accept,
    output mem_req_pkg::mem_status_t       status,
    output dcache_pkg::cache_req_t         cache_req,
    output mem_req_pkg::load_beat_t        load_beat
);
    import mem_req_pkg::*;
    import dcache_pkg::*;

    typedef enum logic [1:0] {st_rest, st_issue, st_wait, st_finish} state_t;

    state_t                state;
    logic [3:0]            elem_idx;
    logic                  beat; // second word of an 8-byte element
    logic [addr_width-1:0] offset; // from the request address
    logic [addr_width-1:0] cur_addr;
    logic [3:0]            addr_inc;
    logic                  elem_active;
    logic                  elems_done;
    logic                  last_beat;
    logic                  cache_idle;
    logic                  cache_done;
    logic [31:0]           store_word;

    always_comb begin
        cur_addr    = plan.addr[addr_width-1:0] + offset;
        elem_active = plan.active[elem_idx[2:0]];
        elems_done  = (elem_idx >= plan.elem_count);
        last_beat   = beat || (plan.elem_beats == 2'd1);
        cache_idle  = (cache_resp.status == cache_resting);
        cache_done  = (cache_resp.status == cache_finished);
        // 8-byte elements move one word per beat
        addr_inc = (plan.elem_beats == 2'd2) ? 4'(beat_bytes) : plan.addr_step;

        case (plan.etype)
            elem_one:  store_word = {24'b0, plan.wdata.lanes[{2'b0, elem_idx[2:0]}]};
            elem_two:  store_word = {16'b0, plan.wdata.lanes[{1'b0, elem_idx[2:0], 1'b1}],
                                     plan.wdata.lanes[{1'b0, elem_idx[2:0], 1'b0}]};
            elem_four: store_word = plan.wdata.beats[elem_idx[2:0]];
            default:   store_word = plan.wdata.beats[{elem_idx[1:0], beat}];
        endcase
    end

    always_comb begin
        accept          = 1'b0;
        status          = mem_working;
        cache_req.cmd   = cache_nop;
        cache_req.addr  = mem_addr_t'(cur_addr);
        cache_req.size  = (plan.etype == elem_eight) ? elem_four : plan.etype;
        cache_req.wdata = store_word;

        case (state)
            st_rest: begin
                status = mem_resting;
                accept = req_valid;
            end
            st_issue: begin
                if (!elems_done && elem_active) begin
                    if (cache_idle) begin
                        cache_req.cmd = (plan.op == op_store) ? cache_store : cache_load;
                    end else begin
                        status = mem_stall; // cache still busy with something
                    end
                end
            end
            st_wait:   status = mem_stall;
            default:   status = mem_finished;
        endcase

        load_beat.valid  = (state == st_wait) && cache_done && (plan.op == op_load);
        load_beat.elem   = elem_idx[2:0];
        load_beat.second = beat;
        load_beat.rdata  = cache_resp.rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_rest;
            elem_idx <= '0;
            beat     <= 1'b0;
            offset   <= '0;
        end else begin
            case (state)
                st_rest: begin
                    if (req_valid) begin
                        elem_idx <= '0;
                        beat     <= 1'b0;
                        offset   <= '0;
                        state    <= st_issue;
                    end
                end
                st_issue: begin
                    if (elems_done) begin
                        state <= st_finish;
                    end else if (!elem_active) begin
                        // masked off, skip without touching the cache
                        elem_idx <= elem_idx + 4'd1;
                        offset   <= offset + addr_width'(plan.addr_step);
                    end else if (cache_idle) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (cache_done) begin
                        if (last_beat) begin
                            elem_idx <= elem_idx + 4'd1;
                            beat     <= 1'b0;
                        end else begin
                            beat <= 1'b1;
                        end
                        offset <= offset + addr_width'(addr_inc);
                        state  <= st_issue;
                    end
                end
                default: state <= st_rest;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/load_assemble.sv */
`timescale 1ns/1ps
`default_nettype none

module load_assemble (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      accept,
    input  wire mem_req_pkg::access_plan_t plan,
    input  wire mem_req_pkg::load_beat_t   load_beat,
    output logic [63:0]                    scalar_data,
    output mem_req_pkg::vreg_t             vector_data
);
    import mem_req_pkg::*;

    logic [4:0] byte_base; // first register lane of this beat
    logic [2:0] beat_len;  // bytes carried by this beat

    always_comb begin
        byte_base = (5'(load_beat.elem) << plan.etype) + (load_beat.second ? 5'd4 : 5'd0);
        if (plan.etype == elem_eight) begin
            beat_len = 3'(beat_bytes);
        end else begin
            beat_len = 3'd1 << plan.etype;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || accept) begin
            // skipped and out-of-count bytes stay zero
            scalar_data <= '0;
            vector_data <= '0;
        end else if (load_beat.valid) begin
            if (plan.is_vector) begin
                for (int k = 0; k < beat_bytes; k++) begin
                    if (k < int'(beat_len)) begin
                        vector_data.lanes[byte_base + 5'(k)] <= load_beat.rdata[8*k +: 8];
                    end
                end
            end else if (plan.etype == elem_eight) begin
                if (load_beat.second) begin
                    scalar_data[63:32] <= load_beat.rdata; // high word
                end else begin
                    scalar_data[31:0] <= load_beat.rdata;
                end
            end else begin
                scalar_data <= {{32{load_beat.rdata[31]}}, load_beat.rdata}; // sign extend
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mem_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_controller #(
    parameter int addr_width = 20
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req_valid,
    input  wire mem_req_pkg::core_req_t req,
    output mem_req_pkg::mem_status_t    status,
    output logic [63:0]                 scalar_data,
    output mem_req_pkg::vreg_t          vector_data,
    output dcache_pkg::cache_req_t      cache_req,
    input  wire dcache_pkg::cache_resp_t cache_resp
);
    import mem_req_pkg::*;

    logic         accept;
    access_plan_t plan;
    load_beat_t   load_beat;

    access_decode #(
        .addr_width (addr_width)
    ) decode (
        .clk    (clk),
        .reset  (reset),
        .accept (accept),
        .req    (req),
        .plan   (plan)
    );

    access_sequencer #(
        .addr_width (addr_width)
    ) execute (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .plan       (plan),
        .cache_resp (cache_resp),
        .accept     (accept),
        .status     (status),
        .cache_req  (cache_req),
        .load_beat  (load_beat)
    );

    load_assemble result (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .plan        (plan),
        .load_beat   (load_beat),
        .scalar_data (scalar_data),
        .vector_data (vector_data)
    );

endmodule

`default_nettype wire

/* dv/mem_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_controller_tb;
    import mem_req_pkg::*;
    import dcache_pkg::*;

    localparam int num_reqs    = 300;
    localparam int cycle_limit = num_reqs * 40;
    localparam int mem_bytes   = 1024;

    logic        clk;
    logic        reset;
    logic        req_valid;
    core_req_t   req;
    mem_status_t status;
    logic [63:0] scalar_data;
    vreg_t       vector_data;
    cache_req_t  cache_req;
    cache_resp_t cache_resp;

    logic [7:0]   cache_mem [mem_bytes];
    logic [7:0]   ref_mem [mem_bytes]; // reference copy
    logic [31:0]  lcg_state;
    int           cycles;
    int           cmd_count;
    int           req_count;
    logic         pending; // cache model owes an answer
    int           busy_left;
    logic [31:0]  load_word;
    mem_status_t  seen_status;
    cache_cmd_t   seen_cmd;
    logic [63:0]  seen_scalar;
    logic [255:0] seen_vector;

    mem_controller #(
        .addr_width (20)
    ) mem_controller_inst (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .status      (status),
        .scalar_data (scalar_data),
        .vector_data (vector_data),
        .cache_req   (cache_req),
        .cache_resp  (cache_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = rand16();
        lo = rand16();
        return {hi, lo};
    endfunction

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] expected);
        if (got !== expected) begin
            $display("FAILED %s got %0h expected %0h", name, got, expected);
            end_with_failure();
        end
    endtask

    // sample at the falling edge, then drive the cache answer just after the rising edge
    task automatic clock_cycle();
        int a;
        int nbytes;
        @(negedge clk);
        seen_status = status;
        seen_cmd    = cache_req.cmd;
        seen_scalar = scalar_data;
        seen_vector = vector_data;
        if (cache_resp.status != cache_resting) begin
            check("status", 256'(status), 256'(mem_stall)); // waiting on the cache
        end
        if (status == mem_stall) begin
            check("cache_req.cmd", 256'(cache_req.cmd), 256'(cache_nop));
        end
        if (cache_req.cmd != cache_nop) begin
            check("cache_resp.status", 256'(cache_resp.status), 256'(cache_resting));
            cmd_count++;
            a = int'(cache_req.addr) % mem_bytes;
            nbytes = 1 << int'(cache_req.size);
            if (cache_req.cmd == cache_store) begin
                for (int b = 0; b < nbytes; b++) begin
                    cache_mem[(a + b) % mem_bytes] = cache_req.wdata[8*b +: 8]; // little endian
                end
            end else begin
                for (int b = 0; b < 4; b++) begin
                    load_word[8*b +: 8] = cache_mem[(a + b) % mem_bytes];
                end
            end
            pending   = 1'b1;
            busy_left = int'(rand16() % 16'd4);
        end
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > cycle_limit) begin
            $display("ERROR: the run did not end within %0d cycles, the DUT seems stuck",
                     cycle_limit);
            end_with_failure();
        end
        if (pending && busy_left > 0) begin
            cache_resp.status = cache_busy;
            cache_resp.rdata  = rand32();
            busy_left--;
        end else if (pending) begin
            cache_resp.status = cache_finished;
            cache_resp.rdata  = load_word;
            pending = 1'b0;
        end else begin
            cache_resp.status = cache_resting;
            cache_resp.rdata  = rand32(); // junk outside finished
        end
    endtask

    task automatic predict_request(input core_req_t r, output logic [63:0] exp_scalar,
                                   output logic [255:0] exp_vector, output int exp_cmds);
        int          esize;
        int          limit;
        int          count;
        int          base;
        int          pos;
        logic [7:0]  act;
        logic [31:0] word;
        exp_scalar = '0;
        exp_vector = '0;
        exp_cmds   = 0;
        base = int'(r.addr);
        if (!r.is_vector) begin
            if (r.etype == elem_four) begin
                for (int b = 0; b < 4; b++) begin
                    word[8*b +: 8] = ref_mem[(base + b) % mem_bytes];
                end
                exp_scalar = {{32{word[31]}}, word};
                exp_cmds = 1;
            end else begin
                for (int b = 0; b < 8; b++) begin
                    if (r.op == op_load) begin
                        exp_scalar[8*b +: 8] = ref_mem[(base + b) % mem_bytes];
                    end else begin
                        ref_mem[(base + b) % mem_bytes] = r.wdata.lanes[b];
                    end
                end
                exp_cmds = 2;
            end
        end else begin
            esize = 1 << int'(r.etype);
            limit = (32 / esize > 8) ? 8 : 32 / esize;
            count = (int'(r.length) > limit) ? limit : int'(r.length);
            act = r.vm ? 8'hff : r.mask;
            for (int e = 0; e < count; e++) begin
                if (act[e]) begin
                    exp_cmds += (esize == 8) ? 2 : 1;
                    for (int b = 0; b < esize; b++) begin
                        pos = e * esize + b;
                        if (r.op == op_load) begin
                            exp_vector[8*pos +: 8] = ref_mem[(base + pos) % mem_bytes];
                        end else begin
                            ref_mem[(base + pos) % mem_bytes] = r.wdata.lanes[pos];
                        end
                    end
                end
            end
        end
    endtask

    function automatic core_req_t random_request();
        core_req_t   r;
        int          kind;
        logic [15:0] v;
        logic [15:0] m;
        r = '0;
        kind = int'(rand16() % 16'd5);
        for (int w = 0; w < 8; w++) begin
            r.wdata.beats[w] = rand32();
        end
        r.is_vector = (kind >= 3);
        r.op    = (kind == 2 || kind == 4) ? op_store : op_load;
        r.etype = (kind == 0) ? elem_four : elem_eight;
        r.addr  = 20'(rand16() % 16'd992);
        if (r.is_vector) begin
            v = rand16();
            m = rand16();
            r.etype  = elem_type_t'(v[1:0]);
            r.length = v[5:2]; // may exceed what fits
            r.vm     = (v[8:6] == 3'd0);
            r.mask   = m[7:0];
            if (v[11:9] == 3'd0) begin
                r.vm   = 1'b0; // every element masked off
                r.mask = '0;
            end
        end
        return r;
    endfunction

    task automatic compare_memory();
        for (int i = 0; i < mem_bytes; i++) begin
            if (cache_mem[i] !== ref_mem[i]) begin
                check($sformatf("cache_mem[%0d]", i), 256'(cache_mem[i]), 256'(ref_mem[i]));
            end
        end
    endtask

    task automatic run_request(input core_req_t r);
        logic [63:0]  exp_scalar;
        logic [255:0] exp_vector;
        int           exp_cmds;
        int           busy_cycles;
        predict_request(r, exp_scalar, exp_vector, exp_cmds);
        req       = r;
        req_valid = 1'b1;
        cmd_count = 0;
        busy_cycles = 0;
        clock_cycle();
        check("status", 256'(seen_status), 256'(mem_resting));
        do begin
            // requests while busy must be ignored
            req_valid = (rand16() % 16'd2) == 16'd1;
            req.addr  = 20'(rand16());
            clock_cycle();
            if (busy_cycles == 0) begin
                check("status", 256'(seen_status), 256'(mem_working)); // first cycle after accept
            end
            busy_cycles++;
        end while (seen_status != mem_finished);
        req_valid = 1'b0;
        check("scalar_data", 256'(seen_scalar), 256'(exp_scalar));
        check("vector_data", seen_vector, exp_vector);
        check("cmd_count", 256'(cmd_count), 256'(exp_cmds));
        clock_cycle();
        check("status", 256'(seen_status), 256'(mem_resting));
        check("scalar_data", 256'(seen_scalar), 256'(exp_scalar)); // held until next accept
        check("vector_data", seen_vector, exp_vector);
        compare_memory();
        req_count++;
    endtask

    initial begin
        logic [15:0] fill;
        core_req_t   r;
        lcg_state  = 32'd98420;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        cache_resp.status = cache_resting;
        cache_resp.rdata  = '0;
        cycles    = 0;
        cmd_count = 0;
        req_count = 0;
        pending   = 1'b0;
        busy_left = 0;
        load_word = '0;
        for (int i = 0; i < mem_bytes; i++) begin
            fill = rand16();
            cache_mem[i] = fill[7:0];
            ref_mem[i]   = fill[7:0];
        end
        repeat (5) clock_cycle();
        reset = 1'b0;
        clock_cycle();
        check("status", 256'(seen_status), 256'(mem_resting));
        check("cache_req.cmd", 256'(seen_cmd), 256'(cache_nop));

        while (req_count < num_reqs) begin
            r = random_request();
            run_request(r);
            if (!r.is_vector && r.op == op_store) begin
                r.op = op_load; // read the doubleword back
                run_request(r);
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_controller.f */
hw/mem_req_pkg.sv
hw/dcache_pkg.sv
hw/access_decode.sv
hw/access_sequencer.sv
hw/load_assemble.sv
hw/mem_controller.sv
dv/mem_controller_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps \
        --top-module mem_controller_tb -f mem_controller.f -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmem_controller_tb)
sim_status=$?
printf '%s\n' "$output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
exit 1
